// File: ast_bus_pkg.sv
// Register bus definitions for the analog sensor top model
// Holds the request and response structs and the register address map
// Import into any block that decodes or drives the register bus
package ast_bus_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  localparam int AstAddrBits = 12;
  localparam int AstDataBits = 32;

  // One-cycle request pulse, no back-pressure
  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [AstAddrBits-1:0] addr;
    logic [AstDataBits-1:0] wdata;
  } ast_bus_req_t;

  // Response comes one cycle after the request
  typedef struct packed {
    logic                   rsp;
    logic [AstDataBits-1:0] rdata;
  } ast_bus_rsp_t;

  //////////////////////////////////////////////////
  // Register address map
  //////////////////////////////////////////////////

  // Power, clock and entropy status, read only
  localparam logic [AstAddrBits-1:0] AddrStatus     = 12'h000;
  // One force pulse per set bit, reads as zero
  localparam logic [AstAddrBits-1:0] AddrAlertForce = 12'h004;
  // Pending alert flags, read only
  localparam logic [AstAddrBits-1:0] AddrAlertState = 12'h008;
  // Current LFSR state, zero extended
  localparam logic [AstAddrBits-1:0] AddrRngData    = 12'h00C;
  // Free read/write word for software
  localparam logic [AstAddrBits-1:0] AddrScratch    = 12'h010;

endpackage

// File: ast_ana_pkg.sv
// Analog side definitions for the analog sensor top model
// Power-good and clock-valid structs, alert naming and LFSR constants
// Import into the power, clock, entropy and alert blocks
package ast_ana_pkg;

  // Number of IO supply rails
  localparam int NumIoRails = 2;

  // Alert count and the index of each sensor alert
  localparam int NumAlerts = 7;
  localparam int AlertAs   = 0;
  localparam int AlertCg   = 1;
  localparam int AlertGd   = 2;
  localparam int AlertTsHi = 3;
  localparam int AlertTsLo = 4;
  localparam int AlertLs   = 5;
  localparam int AlertOt   = 6;

  //////////////////////////////////////////////////
  // Entropy source
  //////////////////////////////////////////////////

  localparam int EntropyStreams = 4;
  localparam int LfsrWidth      = 16;
  localparam logic [LfsrWidth-1:0] LfsrSeed = 16'hACE1;
  // Fibonacci taps 16, 14, 13, 11 as a mask on state bits 15, 13, 12, 10
  localparam logic [LfsrWidth-1:0] LfsrTaps = 16'hB400;

  // Power-good levels, io follows vcc per rail
  typedef struct packed {
    logic                  vcc;
    logic                  aon;
    logic                  main;
    logic [NumIoRails-1:0] io;
  } ast_pok_t;

  // Clock valid flags
  typedef struct packed {
    logic sys;
    logic aon;
    logic usb;
    logic io;
  } ast_clk_val_t;

  // Differential alert, idle is p=0 n=1
  typedef struct packed {
    logic p;
    logic n;
  } ast_alert_pair_t;

endpackage

// File: ast_pwr_seq.sv
// Power-good sequencing model
// vcc rises at the first edge after POR, aon one cycle later
// main goes good once released from power-down and stays good
`timescale 1ns/1ps

module ast_pwr_seq (
  input  logic                  ext_clk_i,
  input  logic                  por_ni,
  input  logic                  main_pd_ni,
  output ast_ana_pkg::ast_pok_t pok_o
);
  import ast_ana_pkg::*;

  logic vcc_q;
  logic aon_q;
  logic main_q;

  // Regulator ramp, aon comes up behind vcc
  always_ff @(posedge ext_clk_i or negedge por_ni) begin
    if (!por_ni) begin
      vcc_q <= 1'b0;
      aon_q <= 1'b0;
    end else begin
      vcc_q <= 1'b1;
      aon_q <= vcc_q;
    end
  end

  // Main domain good is sticky until the next POR
  always_ff @(posedge ext_clk_i or negedge por_ni) begin
    if (!por_ni) begin
      main_q <= 1'b0;
    end else if (main_pd_ni) begin
      main_q <= 1'b1;
    end
  end

  assign pok_o.vcc  = vcc_q;
  assign pok_o.aon  = aon_q;
  assign pok_o.main = main_q;
  // All IO rails track vcc
  assign pok_o.io   = {NumIoRails{vcc_q}};

endmodule

// File: ast_clk_ctrl.sv
// Clock valid flags for the derived clocks
// Each valid is its enable delayed by one reference clock cycle
`timescale 1ns/1ps

module ast_clk_ctrl (
  input  logic                      ext_clk_i,
  input  logic                      por_ni,
  input  logic                      sys_clk_en_i,
  input  logic                      usb_clk_en_i,
  input  logic                      io_clk_en_i,
  output ast_ana_pkg::ast_clk_val_t clk_val_o
);

  logic sys_val_q;
  logic aon_val_q;
  logic usb_val_q;
  logic io_val_q;

  always_ff @(posedge ext_clk_i or negedge por_ni) begin
    if (!por_ni) begin
      sys_val_q <= 1'b0;
      aon_val_q <= 1'b0;
      usb_val_q <= 1'b0;
      io_val_q  <= 1'b0;
    end else begin
      sys_val_q <= sys_clk_en_i;
      // aon runs straight off the reference clock
      aon_val_q <= 1'b1;
      usb_val_q <= usb_clk_en_i;
      io_val_q  <= io_clk_en_i;
    end
  end

  assign clk_val_o.sys = sys_val_q;
  assign clk_val_o.aon = aon_val_q;
  assign clk_val_o.usb = usb_val_q;
  assign clk_val_o.io  = io_val_q;

endmodule

// File: ast_rng.sv
// Pseudo-random entropy source
// A 16-bit Fibonacci LFSR steps on every enabled edge
// The low bits form the entropy stream, the full state is readable over the bus
`timescale 1ns/1ps

module ast_rng (
  input  logic                                   ext_clk_i,
  input  logic                                   por_ni,
  input  logic                                   rng_en_i,
  output logic                                   rng_ok_o,
  output logic [ast_ana_pkg::EntropyStreams-1:0] rng_b_o,
  output logic [ast_ana_pkg::LfsrWidth-1:0]      lfsr_o
);
  import ast_ana_pkg::*;

  logic [LfsrWidth-1:0] lfsr_q;
  logic                 feedback;
  logic                 ok_q;

  //////////////////////////////////////////////////
  // LFSR
  //////////////////////////////////////////////////

  // XOR of the tapped state bits
  assign feedback = ^(lfsr_q & LfsrTaps);

  // Shift left, new bit enters at the bottom
  always_ff @(posedge ext_clk_i or negedge por_ni) begin
    if (!por_ni) begin
      lfsr_q <= LfsrSeed;
    end else if (rng_en_i) begin
      lfsr_q <= {lfsr_q[LfsrWidth-2:0], feedback};
    end
  end

  //////////////////////////////////////////////////
  // Status
  //////////////////////////////////////////////////

  // ok lags the enable by one cycle
  always_ff @(posedge ext_clk_i or negedge por_ni) begin
    if (!por_ni) begin
      ok_q <= 1'b0;
    end else begin
      ok_q <= rng_en_i;
    end
  end

  assign rng_ok_o = ok_q;
  assign rng_b_o  = lfsr_q[EntropyStreams-1:0];
  assign lfsr_o   = lfsr_q;

endmodule

// File: ast_alert_tx.sv
// Differential alert senders for all sensor alerts
// An alert is raised by a force pulse and held until acknowledged
// Each alert leaves as a complementary p/n pair
`timescale 1ns/1ps

module ast_alert_tx (
  input  logic                                  ext_clk_i,
  input  logic                                  por_ni,
  input  logic [ast_ana_pkg::NumAlerts-1:0]     alert_force_i,
  input  logic [ast_ana_pkg::NumAlerts-1:0]     alert_ack_i,
  output ast_ana_pkg::ast_alert_pair_t [ast_ana_pkg::NumAlerts-1:0] alert_o,
  output logic [ast_ana_pkg::NumAlerts-1:0]     alert_state_o
);
  import ast_ana_pkg::*;

  // One pending flag per alert
  logic [NumAlerts-1:0] pend_q;
  logic [NumAlerts-1:0] pend_d;

  //////////////////////////////////////////////////
  // Hold until ack
  //////////////////////////////////////////////////

  // Force wins over a same-cycle ack
  assign pend_d = alert_force_i | (pend_q & ~alert_ack_i);

  always_ff @(posedge ext_clk_i or negedge por_ni) begin
    if (!por_ni) begin
      pend_q <= '0;
    end else begin
      pend_q <= pend_d;
    end
  end

  //////////////////////////////////////////////////
  // Pair encoding
  //////////////////////////////////////////////////

  // Idle pair is p=0 n=1, raised pair is p=1 n=0
  always_comb begin
    for (int i = 0; i < NumAlerts; i++) begin
      alert_o[i].p = pend_q[i];
      alert_o[i].n = ~pend_q[i];
    end
  end

  // Flags go back to the register block for readback
  assign alert_state_o = pend_q;

endmodule

// File: ast_regs.sv
// Register bus decoder for the analog sensor top
// Answers every request one cycle later with registered read data
// Provides status readback, alert force pulses and a scratch word
`timescale 1ns/1ps

module ast_regs (
  input  logic                              ext_clk_i,
  input  logic                              por_ni,
  input  ast_bus_pkg::ast_bus_req_t         bus_req_i,
  input  ast_ana_pkg::ast_pok_t             pok_i,
  input  ast_ana_pkg::ast_clk_val_t         clk_val_i,
  input  logic                              rng_ok_i,
  input  logic [ast_ana_pkg::LfsrWidth-1:0] lfsr_i,
  input  logic [ast_ana_pkg::NumAlerts-1:0] alert_state_i,
  output ast_bus_pkg::ast_bus_rsp_t         bus_rsp_o,
  output logic [ast_ana_pkg::NumAlerts-1:0] alert_force_o
);
  import ast_bus_pkg::*;
  import ast_ana_pkg::*;

  // Status field positions
  localparam int PokBits    = $bits(ast_pok_t);
  localparam int ClkValBits = $bits(ast_clk_val_t);

  logic                   rd_en;
  logic                   wr_en;
  logic [AstDataBits-1:0] rd_data;
  logic [AstDataBits-1:0] scratch_q;
  logic                   rsp_q;
  logic [AstDataBits-1:0] rdata_q;

  assign rd_en = bus_req_i.req & ~bus_req_i.we;
  assign wr_en = bus_req_i.req & bus_req_i.we;

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  // Unused bits stay zero, unmapped and write-only addresses read zero
  always_comb begin
    rd_data = '0;
    case (bus_req_i.addr)
      AddrStatus: begin
        rd_data[PokBits-1:0]                  = pok_i;
        rd_data[PokBits +: ClkValBits]        = clk_val_i;
        rd_data[PokBits + ClkValBits]         = rng_ok_i;
      end
      AddrAlertState: rd_data[NumAlerts-1:0] = alert_state_i;
      AddrRngData:    rd_data[LfsrWidth-1:0] = lfsr_i;
      AddrScratch:    rd_data                = scratch_q;
      default:        rd_data                = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////

  // Force pulse lasts as long as the request, so one cycle
  assign alert_force_o = (wr_en && (bus_req_i.addr == AddrAlertForce)) ?
                         bus_req_i.wdata[NumAlerts-1:0] : '0;

  always_ff @(posedge ext_clk_i or negedge por_ni) begin
    if (!por_ni) begin
      scratch_q <= '0;
    end else if (wr_en && (bus_req_i.addr == AddrScratch)) begin
      scratch_q <= bus_req_i.wdata;
    end
  end

  // Response one cycle after the request, data zero for writes
  always_ff @(posedge ext_clk_i or negedge por_ni) begin
    if (!por_ni) begin
      rsp_q   <= 1'b0;
      rdata_q <= '0;
    end else begin
      rsp_q   <= bus_req_i.req;
      rdata_q <= rd_en ? rd_data : '0;
    end
  end

  assign bus_rsp_o.rsp   = rsp_q;
  assign bus_rsp_o.rdata = rdata_q;

endmodule

// File: ast.sv
// Analog sensor top, behavioral model for digital simulation
// Ties power sequencing, clock valids, entropy, alerts and the register port
// Everything runs on the reference clock with the POR reset
`timescale 1ns/1ps

module ast (
  // Reference clock and power-on reset
  input  logic                                         ext_clk_i,
  input  logic                                         por_ni,

  // Register bus
  input  ast_bus_pkg::ast_bus_req_t                    bus_req_i,
  output ast_bus_pkg::ast_bus_rsp_t                    bus_rsp_o,

  // Power
  input  logic                                         main_pd_ni,
  output ast_ana_pkg::ast_pok_t                        pok_o,

  // Clock enables and valids
  input  logic                                         sys_clk_en_i,
  input  logic                                         usb_clk_en_i,
  input  logic                                         io_clk_en_i,
  output ast_ana_pkg::ast_clk_val_t                    clk_val_o,

  // Entropy
  input  logic                                         rng_en_i,
  output logic                                         rng_ok_o,
  output logic [ast_ana_pkg::EntropyStreams-1:0]       rng_b_o,

  // Alerts
  input  logic [ast_ana_pkg::NumAlerts-1:0]            alert_ack_i,
  output ast_ana_pkg::ast_alert_pair_t [ast_ana_pkg::NumAlerts-1:0] alert_o
);
  import ast_ana_pkg::*;

  // Internal readback and force paths
  logic [LfsrWidth-1:0] lfsr;
  logic [NumAlerts-1:0] alert_state;
  logic [NumAlerts-1:0] alert_force;

  //////////////////////////////////////////////////
  // Power and clocks
  //////////////////////////////////////////////////

  ast_pwr_seq u_pwr_seq (
    .ext_clk_i  (ext_clk_i),
    .por_ni     (por_ni),
    .main_pd_ni (main_pd_ni),
    .pok_o      (pok_o)
  );

  ast_clk_ctrl u_clk_ctrl (
    .ext_clk_i    (ext_clk_i),
    .por_ni       (por_ni),
    .sys_clk_en_i (sys_clk_en_i),
    .usb_clk_en_i (usb_clk_en_i),
    .io_clk_en_i  (io_clk_en_i),
    .clk_val_o    (clk_val_o)
  );

  //////////////////////////////////////////////////
  // Entropy and alerts
  //////////////////////////////////////////////////

  ast_rng u_rng (
    .ext_clk_i (ext_clk_i),
    .por_ni    (por_ni),
    .rng_en_i  (rng_en_i),
    .rng_ok_o  (rng_ok_o),
    .rng_b_o   (rng_b_o),
    .lfsr_o    (lfsr)
  );

  ast_alert_tx u_alert_tx (
    .ext_clk_i     (ext_clk_i),
    .por_ni        (por_ni),
    .alert_force_i (alert_force),
    .alert_ack_i   (alert_ack_i),
    .alert_o       (alert_o),
    .alert_state_o (alert_state)
  );

  // Register port sees the status outputs directly
  ast_regs u_regs (
    .ext_clk_i     (ext_clk_i),
    .por_ni        (por_ni),
    .bus_req_i     (bus_req_i),
    .pok_i         (pok_o),
    .clk_val_i     (clk_val_o),
    .rng_ok_i      (rng_ok_o),
    .lfsr_i        (lfsr),
    .alert_state_i (alert_state),
    .bus_rsp_o     (bus_rsp_o),
    .alert_force_o (alert_force)
  );

endmodule

// File: tb_ast.sv
// Self-checking testbench for the analog sensor top model
// Random bus traffic, enables, acks and power-down release come from a fixed seed
// A cycle model steps on each rising edge and every output is checked on the falling edge
`timescale 1ns/1ps

module tb_ast;
  import ast_bus_pkg::*;
  import ast_ana_pkg::*;

  // Phase lengths in clock cycles
  localparam int PwrCycles   = 20;
  localparam int ClkCycles   = 100;
  localparam int RngCycles   = 200;
  localparam int BusCycles   = 300;
  localparam int AlertCycles = 300;
  localparam int TotalCycles = 3 + PwrCycles + ClkCycles + RngCycles + BusCycles + AlertCycles;
  localparam int PhPwr   = 0;
  localparam int PhClk   = 1;
  localparam int PhRng   = 2;
  localparam int PhBus   = 3;
  localparam int PhAlert = 4;

  logic                                  ext_clk_i = 1'b0;
  logic                                  por_ni;
  ast_bus_req_t                          bus_req_i;
  ast_bus_rsp_t                          bus_rsp_o;
  logic                                  main_pd_ni;
  ast_pok_t                              pok_o;
  logic                                  sys_clk_en_i;
  logic                                  usb_clk_en_i;
  logic                                  io_clk_en_i;
  ast_clk_val_t                          clk_val_o;
  logic                                  rng_en_i;
  logic                                  rng_ok_o;
  logic [EntropyStreams-1:0]             rng_b_o;
  logic [NumAlerts-1:0]                  alert_ack_i;
  ast_alert_pair_t [NumAlerts-1:0]       alert_o;

  integer seed;
  int     main_rel;

  // Reference model state
  ast_pok_t               m_pok;
  ast_clk_val_t           m_clk_val;
  ast_bus_rsp_t           m_rsp;
  logic                   m_rng_ok;
  logic [LfsrWidth-1:0]   m_lfsr;
  logic [NumAlerts-1:0]   m_pend;
  logic [AstDataBits-1:0] m_scratch;

  ast uut (
    .ext_clk_i    (ext_clk_i),
    .por_ni       (por_ni),
    .bus_req_i    (bus_req_i),
    .bus_rsp_o    (bus_rsp_o),
    .main_pd_ni   (main_pd_ni),
    .pok_o        (pok_o),
    .sys_clk_en_i (sys_clk_en_i),
    .usb_clk_en_i (usb_clk_en_i),
    .io_clk_en_i  (io_clk_en_i),
    .clk_val_o    (clk_val_o),
    .rng_en_i     (rng_en_i),
    .rng_ok_o     (rng_ok_o),
    .rng_b_o      (rng_b_o),
    .alert_ack_i  (alert_ack_i),
    .alert_o      (alert_o)
  );

  // 8 ns reference clock
  always #4 ext_clk_i = ~ext_clk_i;

  //////////////////////////////////////////////////
  // Random helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic rand_bit();
    logic [31:0] r;
    r = rand_word();
    return r[0];
  endfunction

  // Mostly mapped addresses, the rest land in an unmapped window
  function automatic logic [AstAddrBits-1:0] random_addr();
    logic [31:0] r;
    r = rand_word();
    case (r[2:0])
      3'd0:       return AddrStatus;
      3'd1:       return AddrAlertForce;
      3'd2:       return AddrAlertState;
      3'd3:       return AddrRngData;
      3'd4, 3'd5: return AddrScratch;
      default:    return {4'h1, r[11:4]};
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Fibonacci step, taps 16 14 13 11
  function automatic logic [LfsrWidth-1:0] lfsr_next(input logic [LfsrWidth-1:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[LfsrWidth-2:0], fb};
  endfunction

  // Read value from the pre-edge model state
  function automatic logic [AstDataBits-1:0] model_read(input logic [AstAddrBits-1:0] addr);
    logic [AstDataBits-1:0] d;
    d = '0;
    case (addr)
      AddrStatus:     d[9:0] = {m_rng_ok, m_clk_val, m_pok};
      AddrAlertState: d[NumAlerts-1:0] = m_pend;
      AddrRngData:    d[LfsrWidth-1:0] = m_lfsr;
      AddrScratch:    d = m_scratch;
      default:        d = '0;
    endcase
    return d;
  endfunction

  task automatic model_reset();
    m_pok     = '0;
    m_clk_val = '0;
    m_rsp     = '0;
    m_rng_ok  = 1'b0;
    m_lfsr    = LfsrSeed;
    m_pend    = '0;
    m_scratch = '0;
  endtask

  // One rising edge, using the inputs held through the past cycle
  task automatic model_step();
    logic [NumAlerts-1:0] force_v;
    force_v = '0;
    m_rsp.rsp   = bus_req_i.req;
    m_rsp.rdata = (bus_req_i.req && !bus_req_i.we) ? model_read(bus_req_i.addr) : '0;
    if (bus_req_i.req && bus_req_i.we && bus_req_i.addr == AddrAlertForce)
      force_v = bus_req_i.wdata[NumAlerts-1:0];
    if (bus_req_i.req && bus_req_i.we && bus_req_i.addr == AddrScratch)
      m_scratch = bus_req_i.wdata;
    // Force beats a same-cycle ack
    m_pend = force_v | (m_pend & ~alert_ack_i);
    m_pok.aon = m_pok.vcc;
    m_pok.vcc = 1'b1;
    m_pok.io  = {NumIoRails{m_pok.vcc}};
    if (main_pd_ni)
      m_pok.main = 1'b1;
    m_clk_val.sys = sys_clk_en_i;
    m_clk_val.aon = 1'b1;
    m_clk_val.usb = usb_clk_en_i;
    m_clk_val.io  = io_clk_en_i;
    m_rng_ok = rng_en_i;
    if (rng_en_i)
      m_lfsr = lfsr_next(m_lfsr);
  endtask

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic report_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("Test failures found");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_pok(input ast_pok_t got, input ast_pok_t exp);
    if (got !== exp)
      report_error($sformatf("pok got %b expected %b", got, exp));
  endtask

  task automatic check_clk_val(input ast_clk_val_t got, input ast_clk_val_t exp);
    if (got !== exp)
      report_error($sformatf("clk_val got %b expected %b", got, exp));
  endtask

  task automatic check_rsp(input ast_bus_rsp_t got, input ast_bus_rsp_t exp);
    if (got !== exp)
      report_error($sformatf("rsp got %b/%h expected %b/%h",
                             got.rsp, got.rdata, exp.rsp, exp.rdata));
  endtask

  // Pairs must match and stay complementary
  task automatic check_alerts(input ast_alert_pair_t [NumAlerts-1:0] got,
                              input ast_alert_pair_t [NumAlerts-1:0] exp);
    for (int i = 0; i < NumAlerts; i++) begin
      if (got[i].n !== ~got[i].p)
        report_error($sformatf("alert %0d pair not complementary %b", i, got[i]));
      if (got[i] !== exp[i])
        report_error($sformatf("alert %0d got %b expected %b", i, got[i], exp[i]));
    end
  endtask

  task automatic check_rng(input logic got_ok, input logic [EntropyStreams-1:0] got_b,
                           input logic exp_ok, input logic [EntropyStreams-1:0] exp_b);
    if (got_ok !== exp_ok || got_b !== exp_b)
      report_error($sformatf("rng got ok=%b b=%h expected ok=%b b=%h",
                             got_ok, got_b, exp_ok, exp_b));
  endtask

  task automatic check_all();
    ast_alert_pair_t [NumAlerts-1:0] exp_alert;
    for (int i = 0; i < NumAlerts; i++) begin
      exp_alert[i].p = m_pend[i];
      exp_alert[i].n = ~m_pend[i];
    end
    check_pok(pok_o, m_pok);
    check_clk_val(clk_val_o, m_clk_val);
    check_rsp(bus_rsp_o, m_rsp);
    check_alerts(alert_o, exp_alert);
    check_rng(rng_ok_o, rng_b_o, m_rng_ok, m_lfsr[EntropyStreams-1:0]);
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Later phases keep the earlier random inputs going
  task automatic drive_inputs(input int phase, input int cyc);
    ast_bus_req_t req;
    logic [31:0]  r;
    int           pick;
    req  = '0;
    pick = rand_word() % 8;
    if (phase == PhPwr)
      main_pd_ni <= (cyc >= main_rel);
    else
      main_pd_ni <= rand_bit();
    if (phase >= PhClk) begin
      sys_clk_en_i <= rand_bit();
      usb_clk_en_i <= rand_bit();
      io_clk_en_i  <= rand_bit();
    end
    if (phase >= PhRng)
      rng_en_i <= rand_bit();
    if (phase == PhRng && pick < 4) begin
      req.req  = 1'b1;
      req.addr = AddrRngData;
    end else if (phase == PhBus && pick < 6) begin
      req.req   = 1'b1;
      req.we    = rand_bit();
      req.addr  = random_addr();
      req.wdata = rand_word();
    end else if (phase == PhAlert && pick < 6) begin
      // Force writes mixed with state reads
      req.req   = 1'b1;
      req.we    = (pick < 2);
      req.addr  = req.we ? AddrAlertForce : AddrAlertState;
      req.wdata = rand_word();
    end
    bus_req_i <= req;
    if (phase == PhAlert) begin
      // Sparse acks, about one bit in four
      r = rand_word() & rand_word();
      alert_ack_i <= r[NumAlerts-1:0];
    end
  endtask

  task automatic run_phase(input int phase, input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge ext_clk_i);
      model_step();
      drive_inputs(phase, i);
      @(negedge ext_clk_i);
      check_all();
    end
  endtask

  initial begin
    seed = 43;
    por_ni       <= 1'b0;
    bus_req_i    <= '0;
    main_pd_ni   <= 1'b0;
    sys_clk_en_i <= 1'b0;
    usb_clk_en_i <= 1'b0;
    io_clk_en_i  <= 1'b0;
    rng_en_i     <= 1'b0;
    alert_ack_i  <= '0;
    model_reset();
    main_rel = 3 + rand_word() % 8;
    // Reset held over two rising edges, outputs idle meanwhile
    @(posedge ext_clk_i);
    @(negedge ext_clk_i);
    check_all();
    @(posedge ext_clk_i);
    por_ni <= 1'b1;
    run_phase(PhPwr, PwrCycles);
    run_phase(PhClk, ClkCycles);
    run_phase(PhRng, RngCycles);
    run_phase(PhBus, BusCycles);
    run_phase(PhAlert, AlertCycles);
    $display("All tests passed!");
    $finish;
  end

  // Watchdog sized from the phase lengths plus margin
  initial begin
    #((TotalCycles + 20) * 8);
    $display("Timeout: the run did not finish within %0d clock cycles", TotalCycles + 20);
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: tb.f
ast_bus_pkg.sv
ast_ana_pkg.sv
ast_pwr_seq.sv
ast_clk_ctrl.sv
ast_rng.sv
ast_alert_tx.sv
ast_regs.sv
ast.sv
tb_ast.sv
